/* clint_subsys.f */
hw/axi_pkg.sv
hw/clint_pkg.sv
hw/axi_lite_if.sv
hw/cmd_capture.sv
hw/cmd_fifo.sv
hw/axil_master.sv
hw/clint.sv
hw/clint_subsys.sv
test/tb_clint_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the clint_subsys testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_clint_subsys -f clint_subsys.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_clint_subsys)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qxF "=== PASS ===" <<< "$sim_out"; then
    exit 0
fi
echo "pass message not found"
exit 1

/* test/tb_clint_subsys.sv */
`timescale 1ns/1ps

module tb_clint_subsys;

    localparam logic [31:0] base       = 32'ha000_0000;
    localparam int          n_steps    = 21;
    localparam int          n_single   = 17;
    localparam int          wait_limit = 200;
    localparam int          poll_limit = 400;

    // data check modes
    localparam logic [1:0] chk_exact    = 2'd0;
    localparam logic [1:0] chk_ignore   = 2'd1;
    localparam logic [1:0] chk_rising   = 2'd2;
    localparam logic [1:0] chk_at_least = 2'd3;

    typedef struct {
        logic        write;
        logic [31:0] offset;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp_data;
        logic [1:0]  mode;
        logic        exp_err;
        logic        exp_irq;
    } step_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cmd_req;
    logic        cmd_write;
    logic [31:0] cmd_addr;
    logic [31:0] cmd_wdata;
    logic [3:0]  cmd_wstrb;
    logic        cmd_ack;
    logic        rsp_req;
    logic        rsp_ack;
    logic [31:0] rsp_rdata;
    logic        rsp_err;
    logic        timer_irq;

    step_t       steps [n_steps];
    int          n_added;
    int          errors;
    int          checks;
    logic [31:0] last_mtime;

    always #20 clk = ~clk;

    clint_subsys #(
        .fifo_depth (4),
        .clint_base (base)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_req   (cmd_req),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .cmd_wstrb (cmd_wstrb),
        .cmd_ack   (cmd_ack),
        .rsp_req   (rsp_req),
        .rsp_ack   (rsp_ack),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err),
        .timer_irq (timer_irq)
    );

    // byte lanes with strobe set take the new value
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic close_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout waiting for %s", what);
        errors++;
        close_run();
    endtask

    task automatic add_step(input logic wr, input logic [31:0] off, input logic [31:0] data,
                            input logic [3:0] strb, input logic [31:0] exp_data,
                            input logic [1:0] mode, input logic exp_err, input logic exp_irq);
        steps[n_added].write    = wr;
        steps[n_added].offset   = off;
        steps[n_added].data     = data;
        steps[n_added].strb     = strb;
        steps[n_added].exp_data = exp_data;
        steps[n_added].mode     = mode;
        steps[n_added].exp_err  = exp_err;
        steps[n_added].exp_irq  = exp_irq;
        n_added++;
    endtask

    task automatic build_table();
        n_added = 0;
        add_step(1'b1, clint_pkg::off_mtimecmp_lo, 32'h0000_0500, 4'hf, 32'h0, chk_ignore, 1'b0, 1'b0);
        add_step(1'b1, clint_pkg::off_mtimecmp_hi, 32'h0, 4'hf, 32'h0, chk_ignore, 1'b0, 1'b0);
        add_step(1'b0, clint_pkg::off_mtimecmp_lo, 32'h0, 4'h0, 32'h0000_0500, chk_exact, 1'b0, 1'b0);
        add_step(1'b0, clint_pkg::off_mtimecmp_hi, 32'h0, 4'h0, 32'h0, chk_exact, 1'b0, 1'b0);
        add_step(1'b1, clint_pkg::off_mtimecmp_lo, 32'h7766_0a55, 4'h2, 32'h0, chk_ignore, 1'b0, 1'b0);
        add_step(1'b0, clint_pkg::off_mtimecmp_lo, 32'h0, 4'h0,
                 merge_bytes(32'h0000_0500, 32'h7766_0a55, 4'h2), chk_exact, 1'b0, 1'b0);
        add_step(1'b1, clint_pkg::off_mtimecmp_lo, 32'h0000_0500, 4'hf, 32'h0, chk_ignore, 1'b0, 1'b0);
        add_step(1'b0, clint_pkg::off_mtime_lo, 32'h0, 4'h0, 32'h0, chk_ignore, 1'b0, 1'b0);
        add_step(1'b0, clint_pkg::off_mtime_lo, 32'h0, 4'h0, 32'h0, chk_rising, 1'b0, 1'b0);
        add_step(1'b0, clint_pkg::off_mtime_hi, 32'h0, 4'h0, 32'h0, chk_exact, 1'b0, 1'b0);
        // polled until mtime has passed the compare value
        add_step(1'b0, clint_pkg::off_mtime_lo, 32'h0, 4'h0, 32'h0000_0500, chk_at_least, 1'b0, 1'b1);
        add_step(1'b1, clint_pkg::off_mtimecmp_lo, 32'hffff_ffff, 4'hf, 32'h0, chk_ignore, 1'b0, 1'b0);
        add_step(1'b1, clint_pkg::off_mtimecmp_hi, 32'hffff_ffff, 4'hf, 32'h0, chk_ignore, 1'b0, 1'b0);
        add_step(1'b0, 32'h0000_0010, 32'h0, 4'h0, 32'h0, chk_exact, 1'b1, 1'b0);
        add_step(1'b1, 32'h0000_0010, 32'h1234_5678, 4'hf, 32'h0, chk_ignore, 1'b1, 1'b0);
        add_step(1'b0, clint_pkg::off_mtimecmp_lo, 32'h0, 4'h0, 32'hffff_ffff, chk_exact, 1'b0, 1'b0);
        add_step(1'b0, clint_pkg::off_mtimecmp_hi, 32'h0, 4'h0, 32'hffff_ffff, chk_exact, 1'b0, 1'b0);
        // issued back to back with rsp_ack held off
        add_step(1'b1, clint_pkg::off_mtimecmp_lo, 32'h00ab_cd00, 4'hf, 32'h0, chk_ignore, 1'b0, 1'b0);
        add_step(1'b0, clint_pkg::off_mtimecmp_lo, 32'h0, 4'h0, 32'h00ab_cd00, chk_exact, 1'b0, 1'b0);
        add_step(1'b0, 32'h0000_0010, 32'h0, 4'h0, 32'h0, chk_exact, 1'b1, 1'b0);
        add_step(1'b0, clint_pkg::off_mtimecmp_hi, 32'h0, 4'h0, 32'hffff_ffff, chk_exact, 1'b0, 1'b0);
    endtask

    task automatic idle_gap();
        repeat ($urandom % 4) @(posedge clk);
    endtask

    task automatic send_cmd(input step_t s);
        int cnt;
        idle_gap();
        @(posedge clk);
        cmd_req   <= 1'b1;
        cmd_write <= s.write;
        cmd_addr  <= base + s.offset;
        cmd_wdata <= s.data;
        cmd_wstrb <= s.strb;
        cnt = 0;
        @(negedge clk);
        while (!cmd_ack && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (!cmd_ack) begin
            report_timeout("cmd_ack to rise");
        end
        @(posedge clk);
        cmd_req <= 1'b0;
        cnt = 0;
        @(negedge clk);
        while (cmd_ack && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (cmd_ack) begin
            report_timeout("cmd_ack to fall");
        end
    endtask

    task automatic collect_rsp(output logic [31:0] data, output logic err);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!rsp_req && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (!rsp_req) begin
            report_timeout("rsp_req to rise");
        end
        data = rsp_rdata;
        err  = rsp_err;
        idle_gap();
        @(posedge clk);
        rsp_ack <= 1'b1;
        cnt = 0;
        @(negedge clk);
        while (rsp_req && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (rsp_req) begin
            report_timeout("rsp_req to fall");
        end
        @(posedge clk);
        rsp_ack <= 1'b0;
    endtask

    task automatic check_step(input int idx, input logic [31:0] data, input logic err);
        step_t s;
        s = steps[idx];
        checks++;
        if (s.mode == chk_exact && data !== s.exp_data) begin
            $display("FAILED step %0d rsp_rdata expected %h got %h", idx, s.exp_data, data);
            errors++;
        end
        if (s.mode == chk_rising && !(data > last_mtime)) begin
            $display("FAILED step %0d rsp_rdata expected above %h got %h", idx, last_mtime, data);
            errors++;
        end
        if (!s.write && s.offset == clint_pkg::off_mtime_lo) begin
            last_mtime = data;
        end
        if (err !== s.exp_err) begin
            $display("FAILED step %0d rsp_err expected %h got %h", idx, s.exp_err, err);
            errors++;
        end
        @(negedge clk);
        if (timer_irq !== s.exp_irq) begin
            $display("FAILED step %0d timer_irq expected %h got %h", idx, s.exp_irq, timer_irq);
            errors++;
        end
    endtask

    task automatic run_single(input int idx);
        step_t       s;
        int          tries;
        logic [31:0] data;
        logic        err;
        s = steps[idx];
        data = '0;
        err = 1'b0;
        tries = 0;
        if (s.mode == chk_at_least) begin
            while (data < s.exp_data && tries < poll_limit) begin
                send_cmd(s);
                collect_rsp(data, err);
                tries++;
            end
            if (data < s.exp_data) begin
                report_timeout("mtime to reach the compare value");
            end
        end else begin
            send_cmd(s);
            collect_rsp(data, err);
        end
        check_step(idx, data, err);
    endtask

    initial begin
        logic [31:0] data;
        logic        err;
        void'($urandom(32'h21a9));
        rst_n     <= 1'b0;
        cmd_req   <= 1'b0;
        cmd_write <= 1'b0;
        cmd_addr  <= '0;
        cmd_wdata <= '0;
        cmd_wstrb <= '0;
        rsp_ack   <= 1'b0;
        errors = 0;
        checks = 0;
        last_mtime = '0;
        build_table();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < n_single; i++) begin
            run_single(i);
        end
        // all four must be accepted before any response is taken
        for (int i = n_single; i < n_steps; i++) begin
            send_cmd(steps[i]);
        end
        for (int i = n_single; i < n_steps; i++) begin
            collect_rsp(data, err);
            check_step(i, data, err);
        end
        close_run();
    end

endmodule

/* hw/clint_subsys.sv */
`timescale 1ns/1ps

module clint_subsys #(
    parameter int unsigned                fifo_depth = 4,
    parameter logic [axi_pkg::addr_w-1:0] clint_base = 32'ha000_0000
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_req,
    input  logic                       cmd_write,
    input  logic [axi_pkg::addr_w-1:0] cmd_addr,
    input  logic [axi_pkg::data_w-1:0] cmd_wdata,
    input  logic [axi_pkg::strb_w-1:0] cmd_wstrb,
    output logic                       cmd_ack,
    output logic                       rsp_req,
    input  logic                       rsp_ack,
    output logic [axi_pkg::data_w-1:0] rsp_rdata,
    output logic                       rsp_err,
    output logic                       timer_irq
);

    logic            push;
    logic            full;
    logic            pop_valid;
    logic            pop_ready;
    clint_pkg::cmd_t push_cmd;
    clint_pkg::cmd_t pop_cmd;

    axi_lite_if axil_bus ();

    cmd_capture capture_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_req   (cmd_req),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .cmd_wstrb (cmd_wstrb),
        .cmd_ack   (cmd_ack),
        .push      (push),
        .push_cmd  (push_cmd),
        .full      (full)
    );

    cmd_fifo #(
        .depth (fifo_depth)
    ) fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_cmd  (push_cmd),
        .full      (full),
        .pop_valid (pop_valid),
        .pop_ready (pop_ready),
        .pop_cmd   (pop_cmd)
    );

    axil_master master_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pop_valid (pop_valid),
        .pop_ready (pop_ready),
        .pop_cmd   (pop_cmd),
        .bus       (axil_bus.master),
        .rsp_req   (rsp_req),
        .rsp_ack   (rsp_ack),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err)
    );

    clint #(
        .base (clint_base)
    ) clint_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (axil_bus.slave),
        .timer_irq (timer_irq)
    );

endmodule

/* hw/clint.sv */
`timescale 1ns/1ps

module clint #(
    parameter logic [axi_pkg::addr_w-1:0] base = 32'ha000_0000
) (
    input  logic       clk,
    input  logic       rst_n,
    axi_lite_if.slave  bus,
    output logic       timer_irq
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_awrite,
        st_write
    } state_t;

    state_t                     state;
    logic [axi_pkg::addr_w-1:0] addr_q;
    logic [axi_pkg::addr_w-1:0] offset;
    logic [63:0]                mtime;
    logic [63:0]                mtimecmp;
    logic                       done;
    logic                       ar_fire;
    logic                       aw_fire;
    logic                       w_fire;
    logic                       r_fire;
    logic                       b_fire;
    logic [axi_pkg::data_w-1:0] rd_data;
    axi_pkg::resp_t             rd_resp;
    axi_pkg::resp_t             wr_resp;

    // read wins when both address channels are valid
    assign bus.arready = (state == st_idle);
    assign bus.awready = (state == st_idle) && !bus.arvalid;
    assign bus.wready  = (state == st_awrite);
    assign bus.rvalid  = (state == st_read) && done;
    assign bus.bvalid  = (state == st_write) && done;

    assign ar_fire = bus.arvalid && bus.arready;
    assign aw_fire = bus.awvalid && bus.awready;
    assign w_fire  = bus.wvalid && bus.wready;
    assign r_fire  = bus.rvalid && bus.rready;
    assign b_fire  = bus.bvalid && bus.bready;

    assign offset    = addr_q - base;
    assign timer_irq = (mtime >= mtimecmp);

    // register decode on the latched address
    always_comb begin
        rd_data = '0;
        rd_resp = axi_pkg::resp_okay;
        wr_resp = axi_pkg::resp_okay;
        case (offset)
            clint_pkg::off_mtimecmp_lo: rd_data = mtimecmp[31:0];
            clint_pkg::off_mtimecmp_hi: rd_data = mtimecmp[63:32];
            clint_pkg::off_mtime_lo:    rd_data = mtime[31:0];
            clint_pkg::off_mtime_hi:    rd_data = mtime[63:32];
            default: begin
                rd_resp = axi_pkg::resp_decerr;
                wr_resp = axi_pkg::resp_decerr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (ar_fire) begin
                        state <= st_read;
                    end else if (aw_fire) begin
                        state <= st_awrite;
                    end
                end
                st_read: begin
                    if (r_fire) begin
                        state <= st_idle;
                    end
                end
                st_awrite: begin
                    if (w_fire) begin
                        state <= st_write;
                    end
                end
                st_write: begin
                    if (b_fire) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
            // one cycle of lookup before valid goes high
            done <= ((state == st_read) && !r_fire) || ((state == st_write) && !b_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            addr_q <= bus.araddr;
        end else if (aw_fire) begin
            addr_q <= bus.awaddr;
        end
        if ((state == st_read) && !done) begin
            bus.rdata <= rd_data;
            bus.rresp <= rd_resp;
        end
        if (w_fire) begin
            bus.bresp <= wr_resp;
        end
    end

    // mtime writes fall through here untouched
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtimecmp <= '1;
        end else if (w_fire) begin
            for (int i = 0; i < axi_pkg::strb_w; i++) begin
                if (bus.wstrb[i] && (offset == clint_pkg::off_mtimecmp_lo)) begin
                    mtimecmp[8*i +: 8] <= bus.wdata[8*i +: 8];
                end
                if (bus.wstrb[i] && (offset == clint_pkg::off_mtimecmp_hi)) begin
                    mtimecmp[32 + 8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

/* hw/axil_master.sv */
`timescale 1ns/1ps

module axil_master (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pop_valid,
    output logic                       pop_ready,
    input  clint_pkg::cmd_t            pop_cmd,
    axi_lite_if.master                 bus,
    output logic                       rsp_req,
    input  logic                       rsp_ack,
    output logic [axi_pkg::data_w-1:0] rsp_rdata,
    output logic                       rsp_err
);

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_wdata,
        st_resp,
        st_rsp_req,
        st_rsp_done
    } state_t;

    state_t          state;
    clint_pkg::cmd_t cmd_q;
    clint_pkg::rsp_t rsp_q;
    logic            rd_done;
    logic            wr_done;

    // one transaction open at a time, so only pop from idle
    assign pop_ready = (state == st_idle);

    assign bus.araddr  = cmd_q.addr;
    assign bus.arvalid = (state == st_addr) && !cmd_q.write;
    assign bus.awaddr  = cmd_q.addr;
    assign bus.awvalid = (state == st_addr) && cmd_q.write;
    assign bus.wdata   = cmd_q.wdata;
    assign bus.wstrb   = cmd_q.wstrb;
    assign bus.wvalid  = (state == st_wdata);
    assign bus.rready  = (state == st_resp) && !cmd_q.write;
    assign bus.bready  = (state == st_resp) && cmd_q.write;

    assign rd_done = bus.rvalid && bus.rready;
    assign wr_done = bus.bvalid && bus.bready;

    assign rsp_req   = (state == st_rsp_req);
    assign rsp_rdata = rsp_q.rdata;
    assign rsp_err   = (rsp_q.resp != axi_pkg::resp_okay);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (pop_valid) begin
                        state <= st_addr;
                    end
                end
                st_addr: begin
                    if (bus.arvalid && bus.arready) begin
                        state <= st_resp;
                    end else if (bus.awvalid && bus.awready) begin
                        state <= st_wdata;
                    end
                end
                st_wdata: begin
                    if (bus.wready) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    if (rd_done || wr_done) begin
                        state <= st_rsp_req;
                    end
                end
                st_rsp_req: begin
                    if (rsp_ack) begin
                        state <= st_rsp_done;
                    end
                end
                // wait for ack low before the next command can answer
                st_rsp_done: begin
                    if (!rsp_ack) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop_valid && pop_ready) begin
            cmd_q <= pop_cmd;
        end
        if (rd_done) begin
            rsp_q.rdata <= bus.rdata;
            rsp_q.resp  <= bus.rresp;
        end
        // writes carry no data back
        if (wr_done) begin
            rsp_q.rdata <= '0;
            rsp_q.resp  <= bus.bresp;
        end
    end

endmodule

/* hw/cmd_fifo.sv */
`timescale 1ns/1ps

module cmd_fifo #(
    parameter int unsigned depth = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  clint_pkg::cmd_t push_cmd,
    output logic            full,
    output logic            pop_valid,
    input  logic            pop_ready,
    output clint_pkg::cmd_t pop_cmd
);

    localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int unsigned cnt_w = $clog2(depth + 1);

    clint_pkg::cmd_t  mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    // head entry is shown directly
    assign pop_cmd   = mem[rd_ptr];
    assign full      = (count == cnt_w'(depth));
    assign pop_valid = (count != '0);
    assign do_push   = push && !full;
    assign do_pop    = pop_valid && pop_ready;

    // wrap for any depth, not only powers of two
    function automatic logic [ptr_w-1:0] advance(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= advance(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= advance(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

endmodule

/* hw/cmd_capture.sv */
`timescale 1ns/1ps

module cmd_capture (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_req,
    input  logic                       cmd_write,
    input  logic [axi_pkg::addr_w-1:0] cmd_addr,
    input  logic [axi_pkg::data_w-1:0] cmd_wdata,
    input  logic [axi_pkg::strb_w-1:0] cmd_wstrb,
    output logic                       cmd_ack,
    output logic                       push,
    output clint_pkg::cmd_t            push_cmd,
    input  logic                       full
);

    typedef enum logic {
        st_wait_req,
        st_ack
    } state_t;

    state_t state;
    logic   take;

    // new request only when the fifo has room
    assign take    = (state == st_wait_req) && cmd_req && !full;
    assign cmd_ack = (state == st_ack);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_wait_req;
            push  <= 1'b0;
        end else begin
            push <= take;
            case (state)
                st_wait_req: begin
                    if (take) begin
                        state <= st_ack;
                    end
                end
                // hold ack until the host lets go of req
                st_ack: begin
                    if (!cmd_req) begin
                        state <= st_wait_req;
                    end
                end
                default: begin
                    state <= st_wait_req;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            push_cmd.write <= cmd_write;
            push_cmd.addr  <= cmd_addr;
            push_cmd.wdata <= cmd_wdata;
            push_cmd.wstrb <= cmd_wstrb;
        end
    end

endmodule

/* hw/axi_lite_if.sv */
`timescale 1ns/1ps

interface axi_lite_if;

    // read address and read data
    logic [axi_pkg::addr_w-1:0] araddr;
    logic                       arvalid;
    logic                       arready;
    logic [axi_pkg::data_w-1:0] rdata;
    axi_pkg::resp_t             rresp;
    logic                       rvalid;
    logic                       rready;

    // write address, write data, write response
    logic [axi_pkg::addr_w-1:0] awaddr;
    logic                       awvalid;
    logic                       awready;
    logic [axi_pkg::data_w-1:0] wdata;
    logic [axi_pkg::strb_w-1:0] wstrb;
    logic                       wvalid;
    logic                       wready;
    axi_pkg::resp_t             bresp;
    logic                       bvalid;
    logic                       bready;

    modport master (
        output araddr, arvalid, rready,
        output awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  arready, rdata, rresp, rvalid,
        input  awready, wready, bresp, bvalid
    );

    modport slave (
        input  araddr, arvalid, rready,
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output arready, rdata, rresp, rvalid,
        output awready, wready, bresp, bvalid
    );

endinterface

/* hw/clint_pkg.sv */
package clint_pkg;

    // byte offsets from the timer base
    localparam logic [axi_pkg::addr_w-1:0] off_mtimecmp_lo = 32'h0000_0040;
    localparam logic [axi_pkg::addr_w-1:0] off_mtimecmp_hi = 32'h0000_0044;
    localparam logic [axi_pkg::addr_w-1:0] off_mtime_lo    = 32'h0000_0048;
    localparam logic [axi_pkg::addr_w-1:0] off_mtime_hi    = 32'h0000_004c;

    // one host command
    typedef struct packed {
        logic                       write;
        logic [axi_pkg::addr_w-1:0] addr;
        logic [axi_pkg::data_w-1:0] wdata;
        logic [axi_pkg::strb_w-1:0] wstrb;
    } cmd_t;

    // one response back to the host
    typedef struct packed {
        logic [axi_pkg::data_w-1:0] rdata;
        axi_pkg::resp_t             resp;
    } rsp_t;

endpackage

/* hw/axi_pkg.sv */
package axi_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // response encoding
    typedef logic [1:0] resp_t;

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_decerr = 2'b11;

endpackage
